// ==== source/heap_settings.svh ====
//------------------------------------------------
// Sizing of the array heap. Included by the package
// and the testbench so that every width agrees.
//------------------------------------------------
`ifndef HEAP_SETTINGS_SVH
`define HEAP_SETTINGS_SVH

// Number of arrays is 2**HEAP_ADDRESS_BITS
`define HEAP_ADDRESS_BITS 3

// Elements per array is 2**HEAP_INDEX_BITS
`define HEAP_INDEX_BITS 3

// Width of one element and of the command operand
`define HEAP_DATA_BITS 16

`endif

// ==== source/heapPkg.sv ====
//------------------------------------------------
// Types shared by the array heap and its testbench.
// Import with heapPkg::* in the module header.
//------------------------------------------------
`default_nettype none
`include "heap_settings.svh"

package heapPkg;

  typedef logic [`HEAP_ADDRESS_BITS-1:0] arrayNumber;  // Selects an array
  typedef logic [`HEAP_INDEX_BITS-1:0]   elementIndex; // Position in an array
  typedef logic [`HEAP_INDEX_BITS:0]     arraySize;    // Zero up to full
  typedef logic [`HEAP_DATA_BITS-1:0]    elementData;  // Element value

  // Command codes, unlisted values are idle
  typedef enum logic [7:0] {
    Nop      = 8'd0,
    Write    = 8'd2,                                   // Store an element
    Read     = 8'd3,
    Size     = 8'd4,
    Less     = 8'd8,                                   // Count below in
    Greater  = 8'd9,                                   // Count above in
    Push     = 8'd14,
    Pop      = 8'd15,
    Alloc    = 8'd18,
    Free     = 8'd19,
    Add      = 8'd20,                                  // Returns new value
    AddAfter = 8'd21,                                  // Returns old value
    Subtract = 8'd22,
    SubAfter = 8'd23,
    Or       = 8'd28,
    Xor      = 8'd29,
    And      = 8'd30
  } heapAction;

  typedef enum logic [2:0] {
    None,
    NotAllocated,                                      // Never handed out
    Freed,                                             // Handed out then freed
    OutOfBounds,                                       // Index at or past size
    Full,                                              // Push on full array
    Empty,                                             // Pop on empty array
    OutOfMemory                                        // No array left
  } heapError;

  // True for every code that does something
  function automatic logic isCommand(heapAction action);
    return action inside {Write, Read, Size, Less, Greater, Push, Pop, Alloc, Free,
                          Add, AddAfter, Subtract, SubAfter, Or, Xor, And};
  endfunction

endpackage

`default_nettype wire

// ==== source/arrayTable.sv ====
//------------------------------------------------
// Bookkeeping of the heap: allocation flags, free
// stack and array sizes. Checks each command and
// picks the element slot the command touches.
//------------------------------------------------
`default_nettype none
`include "heap_settings.svh"

module arrayTable import heapPkg::*; (
  input  wire               clock,
  input  wire               reset,
  input  wire heapAction    action,
  input  wire arrayNumber   array,
  input  wire elementIndex  index,
  output logic              accessOk,                       // Checks passed
  output elementIndex       slot,                           // Element to touch
  output arraySize          currentSize,                    // Size of selected array
  output elementData        tableResult,                    // Alloc and Size result
  output heapError          checkError
);

  localparam int Arrays = 1 << `HEAP_ADDRESS_BITS;

  logic [`HEAP_ADDRESS_BITS:0] allocatedArrays;             // Numbers handed out so far
  logic [`HEAP_ADDRESS_BITS:0] freedTop;                    // Depth of free stack
  logic                        allocations [Arrays];        // Set while in use
  arrayNumber                  freedArrays [Arrays];        // Free stack
  arraySize                    arraySizes  [Arrays];

  logic       handedOut;
  logic       inBounds;
  logic       reuse;
  logic       fresh;
  arrayNumber allocArray;
  heapError   accessError;

  //------------------------------------------------
  // Legality checks
  //------------------------------------------------
  assign handedOut   = {1'b0, array} < allocatedArrays;
  assign currentSize = arraySizes[array];
  assign inBounds    = {1'b0, index} < currentSize;
  assign reuse       = freedTop != '0;                      // Something on free stack
  assign fresh       = !allocatedArrays[`HEAP_ADDRESS_BITS]; // Count below Arrays
  assign allocArray  = reuse ? freedArrays[arrayNumber'(freedTop - 1'b1)]
                             : arrayNumber'(allocatedArrays);

  // Error for an array that is not writeable
  assign accessError = !handedOut          ? NotAllocated :
                       !allocations[array] ? Freed        : None;

  always_comb begin
    checkError = None;
    case (action)
      Write, Size, Less, Greater, Free:
        checkError = accessError;
      Read, Add, AddAfter, Subtract, SubAfter, And, Or, Xor: begin
        checkError = accessError;
        if (accessError == None && !inBounds)
          checkError = OutOfBounds;
      end
      Push: begin
        checkError = accessError;
        if (accessError == None && currentSize[`HEAP_INDEX_BITS]) // Size at full
          checkError = Full;
      end
      Pop: begin
        checkError = accessError;
        if (accessError == None && currentSize == '0)
          checkError = Empty;
      end
      Alloc:
        if (!reuse && !fresh)
          checkError = OutOfMemory;
      default: checkError = None;
    endcase
  end

  assign accessOk = isCommand(action) && checkError == None;

  // Push appends and Pop takes the last element
  always_comb begin
    case (action)
      Push:    slot = elementIndex'(currentSize);
      Pop:     slot = elementIndex'(currentSize - 1'b1);
      default: slot = index;
    endcase
  end

  assign tableResult = (action == Alloc) ? elementData'(allocArray)
                                         : elementData'(currentSize);

  //------------------------------------------------
  // State updates
  //------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      allocatedArrays <= '0;
      freedTop        <= '0;
      for (int i = 0; i < Arrays; i++) begin
        allocations[i] <= 1'b0;
      end
    end else if (accessOk) begin
      case (action)
        Alloc: begin
          if (reuse)
            freedTop <= freedTop - 1'b1;                    // Most recently freed
          else
            allocatedArrays <= allocatedArrays + 1'b1;      // Next unused number
          allocations[allocArray] <= 1'b1;
        end
        Free: begin
          freedTop           <= freedTop + 1'b1;
          allocations[array] <= 1'b0;
        end
        default: ;
      endcase
    end
  end

  // Array sizes and free stack entries
  always_ff @(posedge clock) begin
    if (accessOk) begin
      case (action)
        Write:
          if (!inBounds)
            arraySizes[array] <= arraySize'(index) + 1'b1;  // Grow to cover index
        Push:  arraySizes[array] <= currentSize + 1'b1;
        Pop:   arraySizes[array] <= currentSize - 1'b1;
        Alloc: arraySizes[allocArray] <= '0;
        Free:  freedArrays[arrayNumber'(freedTop)] <= array;
        default: ;
      endcase
    end
  end

  //------------------------------------------------
  // Assertions
  //------------------------------------------------
  // Only handed out arrays can ever be freed
  stackWithinCount: assert property (@(posedge clock) disable iff (!reset)
    freedTop <= allocatedArrays);

  // A successful Free leaves the array unallocated
  freeClearsFlag: assert property (@(posedge clock) disable iff (!reset)
    accessOk && action == Free |=> !allocations[$past(array)]);

endmodule

`default_nettype wire

// ==== source/elementStore.sv ====
//------------------------------------------------
// Element memory of the heap. Does the in-place
// arithmetic and the Less and Greater counts.
//------------------------------------------------
`default_nettype none
`include "heap_settings.svh"

module elementStore import heapPkg::*; (
  input  wire               clock,
  input  wire heapAction    action,
  input  wire arrayNumber   array,
  input  wire elementIndex  slot,                           // From the array table
  input  wire elementData   in,
  input  wire               accessOk,                       // Command is legal
  input  wire arraySize     currentSize,
  output elementData        storeResult
);

  localparam int Length = 1 << `HEAP_INDEX_BITS;
  localparam int Words  = Length << `HEAP_ADDRESS_BITS;

  elementData memory [Words];                               // One block per array
  elementData oldValue;
  elementData newValue;
  elementData writeData;
  elementData element;                                      // Loop scratch
  arraySize   count;
  logic       isArith;
  logic       writeEnable;

  assign oldValue    = memory[{array, slot}];
  assign isArith     = action inside {Add, AddAfter, Subtract, SubAfter, And, Or, Xor};
  assign writeEnable = accessOk && (isArith || action inside {Write, Push});
  assign writeData   = isArith ? newValue : in;

  //------------------------------------------------
  // Arithmetic wraps at element width
  //------------------------------------------------
  always_comb begin
    case (action)
      Add, AddAfter:      newValue = oldValue + in;
      Subtract, SubAfter: newValue = oldValue - in;
      And:                newValue = oldValue & in;
      Or:                 newValue = oldValue | in;
      Xor:                newValue = oldValue ^ in;
      default:            newValue = oldValue;
    endcase
  end

  // Count elements below the size strictly under or over in
  always_comb begin
    count   = '0;
    element = '0;
    for (int i = 0; i < Length; i++) begin
      element = memory[{array, elementIndex'(i)}];
      if (i < int'(currentSize) && (action == Less ? element < in : element > in))
        count = count + 1'b1;
    end
  end

  always_comb begin
    case (action)
      Add, Subtract, And, Or, Xor: storeResult = newValue;
      Less, Greater:               storeResult = elementData'(count);
      Write:                       storeResult = in;
      default:                     storeResult = oldValue;  // Read, Pop and the After forms
    endcase
  end

  always_ff @(posedge clock) begin
    if (writeEnable)
      memory[{array, slot}] <= writeData;
  end

  //------------------------------------------------
  // Arithmetic writes stay inside the array bounds
  // set by the array table
  //------------------------------------------------
  writeLegal: assert property (@(posedge clock)
    writeEnable |-> action inside {Write, Push} || {1'b0, slot} < currentSize);

endmodule

`default_nettype wire

// ==== source/heapResponse.sv ====
//------------------------------------------------
// Output register of the heap. Takes the result
// from the table or the store and holds it.
//------------------------------------------------
`default_nettype none

module heapResponse import heapPkg::*; (
  input  wire              clock,
  input  wire              reset,
  input  wire heapAction   action,
  input  wire elementData  tableResult,                     // Alloc and Size
  input  wire elementData  storeResult,                     // Everything else
  input  wire heapError    checkError,
  output elementData       out,
  output heapError         error
);

  logic hasResult;

  // Free and Push leave out alone
  assign hasResult = isCommand(action) && !(action inside {Free, Push});

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      out   <= '0;
      error <= None;
    end else if (isCommand(action)) begin                   // Idle codes hold both
      error <= checkError;
      if (hasResult && checkError == None)
        out <= (action inside {Alloc, Size}) ? tableResult : storeResult;
    end
  end

  errorKnown: assert property (@(posedge clock) disable iff (!reset)
    !$isunknown(error));

endmodule

`default_nettype wire

// ==== source/arrayHeap.sv ====
//------------------------------------------------
// Top of the array heap. One command per clock,
// result and error one cycle later.
//------------------------------------------------
`default_nettype none

module arrayHeap import heapPkg::*; (
  input  wire              clock,
  input  wire              reset,                           // Async, active low
  input  wire heapAction   action,
  input  wire arrayNumber  array,
  input  wire elementIndex index,
  input  wire elementData  in,
  output elementData       out,
  output heapError         error
);

  logic        accessOk;
  elementIndex slot;
  arraySize    currentSize;
  elementData  tableResult;
  elementData  storeResult;
  heapError    checkError;

  arrayTable arrayTable_inst (
    .clock       (clock),
    .reset       (reset),
    .action      (action),
    .array       (array),
    .index       (index),
    .accessOk    (accessOk),
    .slot        (slot),
    .currentSize (currentSize),
    .tableResult (tableResult),
    .checkError  (checkError)
  );

  elementStore elementStore_inst (
    .clock       (clock),
    .action      (action),
    .array       (array),
    .slot        (slot),
    .in          (in),
    .accessOk    (accessOk),
    .currentSize (currentSize),
    .storeResult (storeResult)
  );

  heapResponse heapResponse_inst (
    .clock       (clock),
    .reset       (reset),
    .action      (action),
    .tableResult (tableResult),
    .storeResult (storeResult),
    .checkError  (checkError),
    .out         (out),
    .error       (error)
  );

endmodule

`default_nettype wire

// ==== dv/arrayHeapTb.sv ====
//------------------------------------------------
// Testbench of the array heap. Runs directed tests
// and random commands, and checks out and error
// against a model of the heap rules every cycle.
//------------------------------------------------
`default_nettype none
`include "heap_settings.svh"

module arrayHeapTb import heapPkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int Arrays         = 1 << `HEAP_ADDRESS_BITS;
  localparam int Length         = 1 << `HEAP_INDEX_BITS;
  localparam int RandomCommands = 500;
  localparam int CycleLimit     = 1500;                     // About twice the test length

  logic        clock;
  logic        reset;
  heapAction   action;
  arrayNumber  array;
  elementIndex index;
  elementData  in;
  elementData  out;
  heapError    error;

  //------------------------------------------------
  // Reference model state
  //------------------------------------------------
  int         modelCount;                                   // Arrays handed out
  logic       modelFlag [Arrays];
  int         modelSize [Arrays];
  elementData modelMem  [Arrays][Length];
  arrayNumber freeStack [$];                                // Back is the top
  elementData expectedOut;
  heapError   expectedError;

  int     checkCount = 0;
  int     errorCount = 0;
  integer seed;

  arrayHeap arrayHeap_inst (
    .clock  (clock),
    .reset  (reset),
    .action (action),
    .array  (array),
    .index  (index),
    .in     (in),
    .out    (out),
    .error  (error)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;                             // 20 ns period
  end

  function automatic void clearModel();
    modelCount    = 0;
    expectedOut   = '0;
    expectedError = None;
    freeStack.delete();
    for (int a = 0; a < Arrays; a++) begin
      modelFlag[a] = 1'b0;
      modelSize[a] = 0;
    end
  endfunction

  function automatic logic knownCommand(input heapAction act);
    case (act)
      Write, Read, Size, Less, Greater, Push, Pop, Alloc, Free,
      Add, AddAfter, Subtract, SubAfter, Or, Xor, And: return 1'b1;
      default: return 1'b0;                                 // Idle codes
    endcase
  endfunction

  function automatic elementData applyOp(input heapAction act, input elementData old,
                                         input elementData value);
    case (act)
      Add, AddAfter:      return old + value;               // Wraps at 16 bits
      Subtract, SubAfter: return old - value;
      And:                return old & value;
      Or:                 return old | value;
      default:            return old ^ value;
    endcase
  endfunction

  //------------------------------------------------
  // Expected out and error of one command
  //------------------------------------------------
  function automatic void predict(input heapAction act, input arrayNumber arr,
                                  input elementIndex idx, input elementData value,
                                  output elementData wantOut, output heapError wantError);
    heapError   fault;
    elementData result;
    int         size;
    int         chosen;
    int         count;
    wantOut   = expectedOut;                                // Held unless a result comes
    wantError = expectedError;
    if (!knownCommand(act))
      return;
    fault  = None;
    result = '0;
    chosen = 0;
    count  = 0;
    size   = modelSize[arr];
    if (act != Alloc) begin
      if (int'(arr) >= modelCount)
        fault = NotAllocated;
      else if (!modelFlag[arr])
        fault = Freed;
    end
    if (fault == None) begin
      case (act)
        Alloc: begin
          if (freeStack.size() > 0) begin
            chosen = int'(freeStack.pop_back());            // Last freed goes first
          end else if (modelCount < Arrays) begin
            chosen     = modelCount;
            modelCount = modelCount + 1;
          end else begin
            fault = OutOfMemory;
          end
          if (fault == None) begin
            modelFlag[chosen] = 1'b1;
            modelSize[chosen] = 0;
            result            = elementData'(chosen);
          end
        end
        Free: begin
          freeStack.push_back(arr);
          modelFlag[arr] = 1'b0;
        end
        Write: begin
          modelMem[arr][idx] = value;
          if (int'(idx) >= size)
            modelSize[arr] = int'(idx) + 1;                 // Grows to cover index
          result = value;
        end
        Size: result = elementData'(size);
        Less, Greater: begin
          for (int i = 0; i < size; i++) begin
            if (act == Less ? modelMem[arr][i] < value : modelMem[arr][i] > value)
              count = count + 1;
          end
          result = elementData'(count);
        end
        Push: begin
          if (size == Length) begin
            fault = Full;
          end else begin
            modelMem[arr][size] = value;
            modelSize[arr]      = size + 1;
          end
        end
        Pop: begin
          if (size == 0) begin
            fault = Empty;
          end else begin
            modelSize[arr] = size - 1;
            result         = modelMem[arr][size - 1];
          end
        end
        default: begin                                      // Read and the arithmetic
          if (int'(idx) >= size) begin
            fault = OutOfBounds;
          end else if (act == Read) begin
            result = modelMem[arr][idx];
          end else begin
            result             = modelMem[arr][idx];        // Old value
            modelMem[arr][idx] = applyOp(act, result, value);
            if (act != AddAfter && act != SubAfter)
              result = modelMem[arr][idx];
          end
        end
      endcase
    end
    wantError = fault;
    if (fault == None && act != Free && act != Push)
      wantOut = result;
  endfunction

  task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // Drive one command 2 ns after the edge
  task automatic issue(input heapAction act, input arrayNumber arr,
                       input elementIndex idx, input elementData value);
    @(posedge clock);
    #2;
    action = act;
    array  = arr;
    index  = idx;
    in     = value;
    predict(act, arr, idx, value, expectedOut, expectedError);
  endtask

  // Idle first so the last command is checked before reset
  task automatic resetDut();
    issue(Nop, '0, '0, '0);
    @(posedge clock);
    #2;
    reset  = 1'b0;
    action = Nop;
    clearModel();
    repeat (4) @(posedge clock);
    #2;
    reset = 1'b1;
  endtask

  //------------------------------------------------
  // Directed tests
  //------------------------------------------------
  task automatic allocTest();
    for (int i = 0; i <= Arrays; i++)
      issue(Alloc, '0, '0, '0);                             // Last one runs out
    issue(Free, arrayNumber'(3), '0, '0);
    issue(Free, arrayNumber'(5), '0, '0);
    issue(Alloc, '0, '0, '0);                               // Gets 5 back
    issue(Alloc, '0, '0, '0);
  endtask

  task automatic tryAccess(input arrayNumber arr);
    issue(Read, arr, '0, '0);
    issue(Write, arr, '0, 16'h1234);
    issue(Size, arr, '0, '0);
    issue(Push, arr, '0, 16'h4321);
    issue(Pop, arr, '0, '0);
    issue(Free, arr, '0, '0);
  endtask

  task automatic accessErrorTest();
    tryAccess(arrayNumber'(2));                             // Never handed out
    issue(Alloc, '0, '0, '0);
    issue(Alloc, '0, '0, '0);
    issue(Free, arrayNumber'(1), '0, '0);
    tryAccess(arrayNumber'(1));                             // Freed array and a second Free
  endtask

  task automatic sizeTest();
    issue(Write, arrayNumber'(0), elementIndex'(2), 16'h00A2);
    issue(Size, arrayNumber'(0), '0, '0);
    issue(Write, arrayNumber'(0), elementIndex'(5), 16'h00A5);
    issue(Size, arrayNumber'(0), '0, '0);
    issue(Read, arrayNumber'(0), elementIndex'(6), '0);     // At the size
    issue(Read, arrayNumber'(0), elementIndex'(7), '0);
    issue(Read, arrayNumber'(0), elementIndex'(2), '0);
    issue(Write, arrayNumber'(0), elementIndex'(1), 16'h00A1);
    issue(Size, arrayNumber'(0), '0, '0);                   // Still six
    issue(Read, arrayNumber'(0), elementIndex'(1), '0);
  endtask

  task automatic stackTest();
    issue(Alloc, '0, '0, '0);                               // Reuses array 1
    for (int k = 0; k < Length; k++)
      issue(Push, arrayNumber'(1), '0, elementData'(16'h1111 * (k + 1)));
    issue(Push, arrayNumber'(1), '0, 16'hDEAD);
    for (int k = 0; k <= Length; k++)
      issue(Pop, arrayNumber'(1), '0, '0);                  // Reverse order then Empty
    issue(Size, arrayNumber'(1), '0, '0);
  endtask

  task automatic arithTest();
    issue(Alloc, '0, '0, '0);                               // Array 2
    issue(Push, arrayNumber'(2), '0, 16'hFFF0);
    issue(Push, arrayNumber'(2), '0, 16'h0005);
    issue(Push, arrayNumber'(2), '0, 16'h0F0F);
    issue(Add, arrayNumber'(2), elementIndex'(0), 16'h0020);        // Wraps
    issue(Read, arrayNumber'(2), elementIndex'(0), '0);
    issue(AddAfter, arrayNumber'(2), elementIndex'(1), 16'hFFFF);
    issue(Read, arrayNumber'(2), elementIndex'(1), '0);
    issue(Subtract, arrayNumber'(2), elementIndex'(1), 16'h000A);   // Below zero
    issue(Read, arrayNumber'(2), elementIndex'(1), '0);
    issue(SubAfter, arrayNumber'(2), elementIndex'(0), 16'h0011);
    issue(Read, arrayNumber'(2), elementIndex'(0), '0);
    issue(And, arrayNumber'(2), elementIndex'(2), 16'h00FF);
    issue(Read, arrayNumber'(2), elementIndex'(2), '0);
    issue(Or, arrayNumber'(2), elementIndex'(2), 16'hA000);
    issue(Read, arrayNumber'(2), elementIndex'(2), '0);
    issue(Xor, arrayNumber'(2), elementIndex'(2), 16'hFFFF);
    issue(Read, arrayNumber'(2), elementIndex'(2), '0);
    issue(Add, arrayNumber'(2), elementIndex'(3), 16'h0001);        // Out of bounds
  endtask

  function automatic heapAction pickAction(input int roll);
    case (roll)
      0, 1:    return Alloc;
      2:       return Free;
      3, 4:    return Write;
      5:       return Read;
      6:       return Size;
      7:       return Less;
      8:       return Greater;
      9, 10:   return Push;
      11:      return Pop;
      12:      return Add;
      13:      return AddAfter;
      14:      return Subtract;
      15:      return SubAfter;
      16:      return And;
      17:      return Or;
      18:      return Xor;
      19:      return Nop;
      default: return heapAction'(8'd1);                    // Unused code
    endcase
  endfunction

  task automatic randomTest();
    heapAction   act;
    arrayNumber  arr;
    elementIndex idx;
    int          limit;
    for (int n = 0; n < RandomCommands; n++) begin
      act = pickAction(int'($unsigned($random(seed)) % 21));
      arr = arrayNumber'($unsigned($random(seed)) % 4);     // A few arrays only
      idx = elementIndex'($unsigned($random(seed)));
      if (act == Write) begin                               // No gaps below the size
        limit = (modelSize[arr] < Length) ? modelSize[arr] + 1 : Length;
        idx   = elementIndex'($unsigned($random(seed)) % limit);
      end
      issue(act, arr, idx, elementData'($random(seed)));
    end
  endtask

  //------------------------------------------------
  // Compare one cycle after each command
  //------------------------------------------------
  initial begin : compareOutputs
    logic       armed;
    heapAction  sampledAction;
    elementData wantOut;
    heapError   wantError;
    forever begin
      @(posedge clock);
      armed         = reset;
      sampledAction = action;
      wantOut       = expectedOut;
      wantError     = expectedError;
      @(negedge clock);
      if (armed && reset) begin
        checkValue(32'(out), 32'(wantOut),
                   $sformatf("out after %s (code %0d)", sampledAction.name(), sampledAction));
        checkValue(32'(error), 32'(wantError),
                   $sformatf("error after %s (code %0d)", sampledAction.name(), sampledAction));
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < CycleLimit) begin
      @(posedge clock);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", CycleLimit);
    $display("checks %0d, mismatches %0d", checkCount, errorCount);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin : runTests
    reset  = 1'b0;
    action = Nop;
    array  = '0;
    index  = '0;
    in     = '0;
    seed   = 13517;
    clearModel();
    resetDut();
    allocTest();
    resetDut();
    accessErrorTest();
    sizeTest();
    stackTest();
    arithTest();
    resetDut();                                             // Fresh heap without gaps
    randomTest();
    issue(Nop, '0, '0, '0);
    repeat (2) @(posedge clock);
    @(negedge clock);
    #1;
    $display("checks %0d, mismatches %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+source
source/heapPkg.sv
source/arrayTable.sv
source/elementStore.sv
source/heapResponse.sv
source/arrayHeap.sv
dv/arrayHeapTb.sv

// ==== Makefile ====
# Verilator build and run of the array heap testbench

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module arrayHeapTb -f sim.f -Mdir obj_dir
	@result=$$(./obj_dir/VarrayHeapTb); \
	echo "$$result"; \
	echo "$$result" | grep -q "^TESTBENCH PASSED$$"

clean:
	rm -rf obj_dir

.PHONY: sim clean
